// ==== armCore.f ====
+incdir+include
src/armIsaPkg.sv
src/armCtrlPkg.sv
src/armAlu.sv
src/armRegFile.sv
src/armDecoder.sv
src/armCondUnit.sv
src/armDatapath.sv
src/armCore.sv
verification/armCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Compile the core and its testbench with Verilator, run it, scan the log

rm -f sim.log

verilator --binary --timing --assert --top-module armCoreTb -f armCore.f \
   -Mdir simBuild -o armCoreSim \
   && ./simBuild/armCoreSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

# The verdict comes from the log
grep -q "test failed" sim.log && exit 1 || exit 0

// ==== src/armAlu.sv ====
//##########################################################################
// ALU of the single-cycle core
// Add, subtract, and, or on two words with NZCV flags; subtract runs
// through the same adder as a plus inverted b plus one
//##########################################################################
`timescale 1ns/1ps

module armAlu (
   input  armIsaPkg::wordT   a,
   input  armIsaPkg::wordT   b,
   input  armCtrlPkg::aluOpT aluOp,
   output armIsaPkg::wordT   result,
   output armCtrlPkg::flagsT flags
);
   import armIsaPkg::*;
   import armCtrlPkg::*;

   logic               isSub;
   logic               isArith;
   wordT               bOperand;
   logic [dataWidth:0] sum;   // Extra bit is carry out

   assign isSub    = (aluOp == aluSub);
   assign isArith  = (aluOp == aluAdd) | isSub;
   assign bOperand = isSub ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, bOperand} + (dataWidth + 1)'(isSub);

   always_comb
   begin
      case (aluOp)
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         default: result = sum[dataWidth-1:0];   // Add and sub
      endcase
   end

   assign flags.neg   = result[dataWidth-1];
   assign flags.zero  = (result == '0);
   assign flags.carry = isArith & sum[dataWidth];
   // Operands agree in sign, sum does not
   assign flags.overflow = isArith
                         & ~(a[dataWidth-1] ^ bOperand[dataWidth-1])
                         & (a[dataWidth-1] ^ sum[dataWidth-1]);

endmodule

// ==== src/armCondUnit.sv ====
//##########################################################################
// Condition unit of the single-cycle core
// Holds the NZ and CV flag groups, evaluates the condition field of the
// current instruction and gates every write request with the result
//##########################################################################
`timescale 1ns/1ps

module armCondUnit (
   input  logic              clk,
   input  logic              reset,
   input  armIsaPkg::condT   cond,
   input  armCtrlPkg::flagsT aluFlags,
   input  armCtrlPkg::ctrlT  ctrl,
   output logic              regWrite,
   output logic              memWrite,
   output logic              pcSrc
);
   import armIsaPkg::*;
   import armCtrlPkg::*;

   flagsT flags;
   logic  condEx;
   logic  ge;

   // NZ and CV update as separate groups
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (ctrl.flagWNz && condEx)
         begin
            flags.neg  <= aluFlags.neg;
            flags.zero <= aluFlags.zero;
         end
         if (ctrl.flagWCv && condEx)
         begin
            flags.carry    <= aluFlags.carry;
            flags.overflow <= aluFlags.overflow;
         end
      end
   end

   assign ge = (flags.neg == flags.overflow);   // Signed greater or equal

   always_comb
   begin
      case (cond)
         condEq:  condEx = flags.zero;
         condNe:  condEx = ~flags.zero;
         condCs:  condEx = flags.carry;
         condCc:  condEx = ~flags.carry;
         condMi:  condEx = flags.neg;
         condPl:  condEx = ~flags.neg;
         condVs:  condEx = flags.overflow;
         condVc:  condEx = ~flags.overflow;
         condHi:  condEx = flags.carry & ~flags.zero;
         condLs:  condEx = ~flags.carry | flags.zero;
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~flags.zero & ge;
         condLe:  condEx = flags.zero | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;   // 4'b1111 never executes
      endcase
   end

   assign regWrite = ctrl.regW & condEx;
   assign memWrite = ctrl.memW & condEx;
   assign pcSrc    = ctrl.pcS  & condEx;

   // Stores and register writes come from disjoint decodes
   noStoreAndWrite: assert property (@(posedge clk) disable iff (reset)
      !(memWrite && regWrite));

endmodule

// ==== src/armCore.sv ====
//##########################################################################
// Top level of the single-cycle ARMv4 subset core
// One instruction per clock from the instruction port; data memory is
// addressed by aluResult and answers readData in the same cycle
//##########################################################################
`timescale 1ns/1ps

module armCore (
   input  logic             clk,
   input  logic             reset,
   input  armIsaPkg::instrT instr,
   input  armIsaPkg::wordT  readData,
   output armIsaPkg::wordT  pc,
   output armIsaPkg::wordT  aluResult,
   output armIsaPkg::wordT  writeData,
   output logic             memWrite
);
   import armIsaPkg::*;
   import armCtrlPkg::*;

   ctrlT  ctrl;       // Ungated decode
   flagsT aluFlags;
   logic  regWrite;
   logic  pcSrc;

   armDecoder decoder_i (
      .op    (instr.op),
      .funct (instr.funct),
      .rd    (instr.rd),
      .ctrl  (ctrl)
   );

   armCondUnit condUnit_i (
      .clk      (clk),
      .reset    (reset),
      .cond     (instr.cond),
      .aluFlags (aluFlags),
      .ctrl     (ctrl),
      .regWrite (regWrite),
      .memWrite (memWrite),
      .pcSrc    (pcSrc)
   );

   armDatapath datapath_i (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .ctrl      (ctrl),
      .regWrite  (regWrite),
      .pcSrc     (pcSrc),
      .readData  (readData),
      .pc        (pc),
      .aluResult (aluResult),
      .writeData (writeData),
      .aluFlags  (aluFlags)
   );

endmodule

// ==== src/armCtrlPkg.sv ====
//##########################################################################
// Control types shared by the decoder, condition unit and datapath
// The control word travels as one struct from the decoder; the ALU
// reports its flags as a struct to the condition unit
//##########################################################################
package armCtrlPkg;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOrr
   } aluOpT;

   // Which immediate the extender builds
   typedef enum logic [1:0] {
      immByte,     // Zero-extended imm8
      immOffset,   // Zero-extended imm12
      immBranch    // Sign-extended imm24, word scaled
   } immSrcT;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flagsT;

   typedef struct packed {
      logic   regSrcA;    // Read R15 on port A
      logic   regSrcB;    // Read rd on port B
      immSrcT immSrc;
      logic   aluSrc;     // Immediate as operand B
      logic   memToReg;
      logic   regW;
      logic   memW;
      logic   pcS;        // Request PC load
      aluOpT  aluOp;
      logic   flagWNz;
      logic   flagWCv;
   } ctrlT;

endpackage

// ==== src/armDatapath.sv ====
//##########################################################################
// Datapath of the single-cycle core
// PC register and next-PC select, register address and immediate
// selection, operand and write-back muxes around register file and ALU
// Steered by the control word and the gated strobes of the condition unit
//##########################################################################
`timescale 1ns/1ps

module armDatapath (
   input  logic              clk,
   input  logic              reset,
   input  armIsaPkg::instrT  instr,
   input  armCtrlPkg::ctrlT  ctrl,
   input  logic              regWrite,
   input  logic              pcSrc,
   input  armIsaPkg::wordT   readData,
   output armIsaPkg::wordT   pc,
   output armIsaPkg::wordT   aluResult,
   output armIsaPkg::wordT   writeData,
   output armCtrlPkg::flagsT aluFlags
);
   import armIsaPkg::*;
   import armCtrlPkg::*;

   wordT        pcPlus4;
   wordT        pcPlus8;
   wordT        pcNext;
   wordT        extImm;
   wordT        srcA;
   wordT        srcB;
   wordT        result;
   regAddrT     ra1;
   regAddrT     ra2;
   logic        rfWrite;
   logic [23:0] imm24;

   assign pcPlus4 = pc + wordT'(pcStep);
   assign pcPlus8 = pcPlus4 + wordT'(pcStep);   // What R15 reads as
   assign pcNext  = pcSrc ? result : pcPlus4;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         pc <= '0;
      else
         pc <= pcNext;
   end

   assign ra1 = ctrl.regSrcA ? regAddrT'(pcRegIdx) : instr.rn;
   assign ra2 = ctrl.regSrcB ? instr.rd : instr.operand2[3:0];   // rd or rm

   assign imm24 = instr[23:0];

   always_comb
   begin
      case (ctrl.immSrc)
         immByte:   extImm = {24'b0, instr.operand2[7:0]};
         immOffset: extImm = {20'b0, instr.operand2};
         immBranch: extImm = {{6{imm24[23]}}, imm24, 2'b00};
         default:   extImm = '0;
      endcase
   end

   // R15 destination goes to the PC only
   assign rfWrite = regWrite & (instr.rd != regAddrT'(pcRegIdx));

   armRegFile regFile_i (
      .clk   (clk),
      .reset (reset),
      .we    (rfWrite),
      .ra1   (ra1),
      .ra2   (ra2),
      .wa    (instr.rd),
      .wd    (result),
      .r15   (pcPlus8),
      .rd1   (srcA),
      .rd2   (writeData)
   );

   assign srcB = ctrl.aluSrc ? extImm : writeData;

   armAlu alu_i (
      .a      (srcA),
      .b      (srcB),
      .aluOp  (ctrl.aluOp),
      .result (aluResult),
      .flags  (aluFlags)
   );

   assign result = ctrl.memToReg ? readData : aluResult;   // Load or ALU

endmodule

// ==== src/armDecoder.sv ====
//##########################################################################
// Instruction decoder of the single-cycle core
// Turns opcode, funct and rd into the unconditional control word;
// the condition unit gates its write requests afterwards
//##########################################################################
`timescale 1ns/1ps

module armDecoder (
   input  armIsaPkg::opT    op,
   input  armIsaPkg::functT funct,
   input  armIsaPkg::regAddrT rd,
   output armCtrlPkg::ctrlT ctrl
);
   import armIsaPkg::*;
   import armCtrlPkg::*;

   cmdT  cmd;
   logic branch;

   assign cmd = funct[4:1];

   always_comb
   begin
      ctrl   = '0;
      branch = 1'b0;
      case (op)
         opDataProc:
         begin
            ctrl.immSrc = immByte;
            ctrl.aluSrc = funct[5];   // I bit
            ctrl.regW   = 1'b1;
            case (cmd)
               cmdSub:  ctrl.aluOp = aluSub;
               cmdAnd:  ctrl.aluOp = aluAnd;
               cmdOrr:  ctrl.aluOp = aluOrr;
               default: ctrl.aluOp = aluAdd;
            endcase
            ctrl.flagWNz = funct[0];
            // Logical ops leave C and V alone
            ctrl.flagWCv = funct[0] & ((cmd == cmdAdd) | (cmd == cmdSub));
         end
         opMemory:
         begin
            ctrl.regSrcB = 1'b1;        // Store data from rd
            ctrl.immSrc  = immOffset;
            ctrl.aluSrc  = 1'b1;
            ctrl.aluOp   = aluAdd;      // Base plus offset
            if (funct[0])               // L bit
            begin
               ctrl.memToReg = 1'b1;
               ctrl.regW     = 1'b1;
            end
            else
               ctrl.memW = 1'b1;
         end
         opBranch:
         begin
            ctrl.regSrcA = 1'b1;        // PC+8 as base
            ctrl.immSrc  = immBranch;
            ctrl.aluSrc  = 1'b1;
            ctrl.aluOp   = aluAdd;
            branch       = 1'b1;
         end
         default: ;                     // Unused opcode does nothing
      endcase
      // Any write to R15 becomes a jump
      ctrl.pcS = branch | (ctrl.regW & (rd == regAddrT'(pcRegIdx)));
      opcodeUsed: assert (op !== 2'b11)
         else $error("Unused opcode 2'b11 decoded");
   end

endmodule

// ==== src/armIsaPkg.sv ====
//##########################################################################
// Instruction set encoding for the single-cycle ARMv4 subset core
// Word and register types, the instruction field layout and the names
// of the condition, opcode and command values
// Imported by every RTL module and by the reference model
//##########################################################################
package armIsaPkg;

   localparam int dataWidth = 32;
   localparam int regCount  = 16;
   localparam int pcRegIdx  = 15;   // R15 names the PC
   localparam int pcStep    = 4;    // Bytes per instruction

   typedef logic [dataWidth-1:0]        wordT;
   typedef logic [$clog2(regCount)-1:0] regAddrT;

   // Condition field, bits 31:28
   typedef logic [3:0] condT;
   localparam condT condEq = 4'b0000;   // Z
   localparam condT condNe = 4'b0001;   // !Z
   localparam condT condCs = 4'b0010;   // C
   localparam condT condCc = 4'b0011;   // !C
   localparam condT condMi = 4'b0100;   // N
   localparam condT condPl = 4'b0101;   // !N
   localparam condT condVs = 4'b0110;   // V
   localparam condT condVc = 4'b0111;   // !V
   localparam condT condHi = 4'b1000;   // Unsigned higher
   localparam condT condLs = 4'b1001;   // Unsigned lower or same
   localparam condT condGe = 4'b1010;   // N == V
   localparam condT condLt = 4'b1011;   // N != V
   localparam condT condGt = 4'b1100;
   localparam condT condLe = 4'b1101;
   localparam condT condAl = 4'b1110;   // Always

   // Opcode, bits 27:26; 2'b11 is not used
   typedef logic [1:0] opT;
   localparam opT opDataProc = 2'b00;
   localparam opT opMemory   = 2'b01;
   localparam opT opBranch   = 2'b10;

   // Funct is I, cmd[3:0], S for data processing
   typedef logic [5:0] functT;

   typedef logic [3:0] cmdT;
   localparam cmdT cmdAnd = 4'b0000;
   localparam cmdT cmdSub = 4'b0010;
   localparam cmdT cmdAdd = 4'b0100;
   localparam cmdT cmdOrr = 4'b1100;

   typedef struct packed {
      condT        cond;
      opT          op;
      functT       funct;
      regAddrT     rn;
      regAddrT     rd;
      logic [11:0] operand2;   // imm8, rm or imm12
   } instrT;

endpackage

// ==== src/armRegFile.sv ====
//##########################################################################
// Register file of the single-cycle core
// R0 to R14 with two combinational read ports and one write port;
// address fifteen reads the supplied PC+8 instead of storage
//##########################################################################
`timescale 1ns/1ps

module armRegFile (
   input  logic               clk,
   input  logic               reset,
   input  logic               we,
   input  armIsaPkg::regAddrT ra1,
   input  armIsaPkg::regAddrT ra2,
   input  armIsaPkg::regAddrT wa,
   input  armIsaPkg::wordT    wd,
   input  armIsaPkg::wordT    r15,
   output armIsaPkg::wordT    rd1,
   output armIsaPkg::wordT    rd2
);
   import armIsaPkg::*;

   wordT regs [0:pcRegIdx-1];   // No storage behind R15

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         for (int i = 0; i < pcRegIdx; i++)
            regs[i] <= '0;
      else if (we)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == regAddrT'(pcRegIdx)) ? r15 : regs[ra1];
   assign rd2 = (ra2 == regAddrT'(pcRegIdx)) ? r15 : regs[ra2];

   // Datapath diverts R15 writes to the PC
   noPcWrite: assert property (@(posedge clk) disable iff (reset)
      we |-> (wa != regAddrT'(pcRegIdx)));

endmodule

// ==== include/armRefModel.svh ====
//##########################################################################
// Instruction-level reference model and random instruction generator
// Included inside the testbench module after its armIsaPkg import;
// randomInstr gives a legal instruction and executeInstr steps the
// model, leaving the expected bus values in the exp* variables
//##########################################################################
`ifndef ARM_REF_MODEL_SVH
`define ARM_REF_MODEL_SVH

wordT modelRegs [regCount];
wordT modelMem  [256];   // Word memory, address bits 9:2
wordT modelPc;
wordT nextPc;
logic flagN;
logic flagZ;
logic flagC;
logic flagV;
// Expected DUT outputs for the last executed instruction
wordT expResult;
wordT expWriteData;
logic expMemWrite;

function automatic void clearModel();
   for (int i = 0; i < regCount; i++)
      modelRegs[i] = '0;
   for (int i = 0; i < 256; i++)
      modelMem[i] = '0;
   modelPc = '0;
   nextPc  = '0;
   flagN   = 1'b0;
   flagZ   = 1'b0;
   flagC   = 1'b0;
   flagV   = 1'b0;
endfunction

function automatic int memIndex(wordT addr);
   return int'(addr[9:2]);
endfunction

function automatic wordT readReg(regAddrT r);
   return (r == regAddrT'(pcRegIdx)) ? modelPc + 8 : modelRegs[r];
endfunction

function automatic void writeReg(regAddrT r, wordT val);
   if (r == regAddrT'(pcRegIdx))
      nextPc = val;   // Jump
   else
      modelRegs[r] = val;
endfunction

// Odd codes invert the even one below them; 4'b1111 fails
function automatic logic condPass(condT cond);
   logic r;
   case (cond[3:1])
      3'd0: r = flagZ;
      3'd1: r = flagC;
      3'd2: r = flagN;
      3'd3: r = flagV;
      3'd4: r = flagC & ~flagZ;
      3'd5: r = (flagN == flagV);
      3'd6: r = ~flagZ & (flagN == flagV);
      default: r = 1'b1;
   endcase
   return cond[0] ? ~r : r;
endfunction

function automatic instrT randomInstr();
   instrT ins;
   int    off;
   ins      = $urandom;
   ins.cond = condT'($urandom_range(14, 0));
   off      = int'($urandom_range(32, 0)) - 16;   // Short branch
   case ($urandom_range(2, 0))
      0:
      begin
         ins.op = opDataProc;
         case ($urandom_range(3, 0))
            0: ins.funct[4:1] = cmdAnd;
            1: ins.funct[4:1] = cmdSub;
            2: ins.funct[4:1] = cmdAdd;
            default: ins.funct[4:1] = cmdOrr;
         endcase
         ins.operand2[11:8] = 4'b0;
         if (!ins.funct[5])
            ins.operand2[7:4] = 4'b0;   // Plain rm, no shift
      end
      1:
      begin
         ins.op         = opMemory;
         ins.funct[5:1] = 5'b01100;
         ins.operand2   = {2'b00, 8'($urandom_range(255, 0)), 2'b00};
      end
      default:
      begin
         ins.op         = opBranch;
         ins.funct[5:4] = 2'b10;   // B without link
         ins[23:0]      = 24'(off);
      end
   endcase
   return ins;
endfunction

function automatic void executeInstr(instrT ins);
   wordT a;
   wordT b;
   wordT res;
   logic pass;
   logic isSub;
   logic isArith;
   pass    = condPass(ins.cond);
   isSub   = (ins.funct[4:1] == cmdSub);
   isArith = isSub || (ins.funct[4:1] == cmdAdd);
   a       = readReg(ins.rn);
   nextPc  = modelPc + 4;
   expWriteData = readReg((ins.op == opMemory) ? ins.rd : ins.operand2[3:0]);
   expMemWrite  = 1'b0;
   case (ins.op)
      opDataProc:
      begin
         b = ins.funct[5] ? {24'b0, ins.operand2[7:0]} : expWriteData;
         case (ins.funct[4:1])
            cmdAnd:  res = a & b;
            cmdOrr:  res = a | b;
            cmdSub:  res = a - b;
            default: res = a + b;
         endcase
         if (pass && ins.funct[0])
         begin
            flagN = res[31];
            flagZ = (res == '0);
            if (isArith)
            begin
               // SUB carry means no borrow, ADD carry means the sum wrapped
               flagC = isSub ? (a >= b) : (res < a);
               flagV = isSub ? ((a[31] != b[31]) && (res[31] != a[31]))
                             : ((a[31] == b[31]) && (res[31] != a[31]));
            end
         end
         if (pass)
            writeReg(ins.rd, res);
      end
      opMemory:
      begin
         res         = a + {20'b0, ins.operand2};
         expMemWrite = pass & ~ins.funct[0];
         if (pass && ins.funct[0])
            writeReg(ins.rd, modelMem[memIndex(res)]);
         if (expMemWrite)
            modelMem[memIndex(res)] = expWriteData;
      end
      default:
      begin
         res = modelPc + 8 + 4 * int'($signed(ins[23:0]));   // Word offset
         if (pass)
            nextPc = res;
      end
   endcase
   expResult = res;
   modelPc   = nextPc;
endfunction

`endif

// ==== verification/armCoreTb.sv ====
//##########################################################################
// Testbench for the single-cycle ARMv4 subset core
// Feeds one random legal instruction per clock, serves data memory from
// aluResult and compares pc and the bus outputs with the reference model
// Closes with the error counts and the run verdict
//##########################################################################
`timescale 1ns/1ps

module armCoreTb;
   import armIsaPkg::*;

   localparam int clkHalf       = 20;    // 40 ns period
   localparam int resetCycles   = 10;
   localparam int numInstr      = 2000;
   localparam int timeoutCycles = resetCycles + numInstr + 90;
   localparam int memWords      = 256;

   logic  clk;
   logic  reset;
   instrT instr;
   wordT  readData;
   wordT  pc;
   wordT  aluResult;
   wordT  writeData;
   logic  memWrite;

   wordT  dataMem [memWords];   // Word addressed by aluResult[9:2]
   int    wordErrors;
   int    strobeErrors;
   int    cycleCount;
   int    instrIdx;             // Instruction under check, for error lines

`include "armRefModel.svh"

   armCore armCore_i (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .readData  (readData),
      .pc        (pc),
      .aluResult (aluResult),
      .writeData (writeData),
      .memWrite  (memWrite)
   );

   always #clkHalf clk = ~clk;

   // Data memory, combinational read and edge write
   assign readData = dataMem[aluResult[9:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         dataMem[aluResult[9:2]] <= writeData;
   end

   // Compare a word output with the model
   task automatic checkWord(input string name, input wordT actual, input wordT expected);
      if (actual !== expected)
      begin
         wordErrors++;
         $display("Fail %s at instruction %0d: got %h expected %h",
                  name, instrIdx, actual, expected);
      end
   endtask

   // Compare a single strobe level with the model
   task automatic checkStrobe(input string name, input logic actual, input logic expected);
      if (actual !== expected)
      begin
         strobeErrors++;
         $display("Fail %s at instruction %0d: got %h expected %h",
                  name, instrIdx, actual, expected);
      end
   endtask

   // Guard against a stuck run
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= timeoutCycles)
      begin
         $display("Timeout: the run did not end within %0d cycles", timeoutCycles);
         $display("test failed");
         $finish;
      end
   end

   initial
   begin
      instrT nextInstr;
      clk          = 1'b0;
      reset        = 1'b1;
      instr        = '0;   // ANDEQ, legal while reset holds
      wordErrors   = 0;
      strobeErrors = 0;
      cycleCount   = 0;
      instrIdx     = 0;
      for (int i = 0; i < memWords; i++)
         dataMem[i] <= '0;
      void'($urandom(32'hb2e4_445c));   // Seed once
      clearModel();

      repeat (resetCycles) @(posedge clk);
      for (int i = 0; i < numInstr; i++)
      begin
         nextInstr = randomInstr();
         instrIdx  = i;
         reset <= 1'b0;        // Released with the first instruction
         instr <= nextInstr;
         @(negedge clk);       // Outputs settled mid cycle
         checkWord("pc", pc, modelPc);
         executeInstr(nextInstr);
         checkWord("aluResult", aluResult, expResult);
         checkWord("writeData", writeData, expWriteData);
         checkStrobe("memWrite", memWrite, expMemWrite);
         @(posedge clk);
      end

      // Effect of the last instruction on the PC
      instrIdx = numInstr;
      @(negedge clk);
      checkWord("pc", pc, modelPc);

      $display("Errors: %0d word, %0d strobe, %0d total",
               wordErrors, strobeErrors, wordErrors + strobeErrors);
      if (wordErrors + strobeErrors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
